// File: sources.f
verilog/pc_pkg.sv
verilog/csr_pkg.sv
verilog/pc_redirect_detect.sv
verilog/pc_next_sel.sv
verilog/pc_cov_counters.sv
verilog/pc_unit_top.sv
bench/pc_unit_tb.sv

// File: Makefile
# Verilator build and run of the next-PC unit testbench

VERILATOR ?= verilator
TOP       ?= pc_unit_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/pc_unit_tb.sv
// Stimulus from a 16-bit LFSR with seed 38629; boot PC near the top makes sequential fetch wrap
`timescale 1ns/10ps
`default_nettype none

module pc_unit_tb;

  import pc_pkg::*;
  import csr_pkg::*;

  localparam int          tag_width_lp   = 10;
  localparam int          entries_lp     = 64;
  localparam int          pc_width_lp    = tag_width_lp + $clog2(entries_lp);
  localparam int unsigned boot_pc_lp     = 32'h0000_fff8;
  localparam int unsigned intr_vector_lp = 32'h0000_0200;
  localparam logic [pc_width_lp-1:0] boot_addr_lp = boot_pc_lp[pc_width_lp-1:0];
  localparam logic [pc_width_lp-1:0] intr_addr_lp = intr_vector_lp[pc_width_lp-1:0];

  localparam int clk_period_lp   = 20;
  localparam int wrap_cycles_lp  = 12;
  localparam int main_cycles_lp  = 3000;
  localparam int idle_cycles_lp  = 50;
  localparam int total_cycles_lp = 2 * pc_src_count_lp + wrap_cycles_lp + main_cycles_lp
                                   + idle_cycles_lp + 4;
  localparam int mode_hold   = 0;
  localparam int mode_seq    = 1;
  localparam int mode_random = 2;
  localparam logic [15:0] seed_lp = 16'd38629;
  localparam logic [cov_cnt_width_lp-1:0] cnt_one_lp = cov_cnt_width_lp'(1);

  logic clk;
  logic rst;
  logic hold_down;
  decode_s decode;
  logic [pc_width_lp-1:0] decode_target;
  exe_s exe;
  logic [pc_width_lp-1:0] exe_pc_plus1;
  logic [pc_width_lp-1:0] exe_pred_or_jump_addr;
  logic mem_icache_miss;
  logic wb_icache_miss;
  logic [pc_width_lp-1:0] wb_pc;
  logic alu_jump_now;
  logic [pc_width_lp-1:0] alu_jalr_addr;
  csr_mstatus_s mstatus;
  csr_interrupt_vector_s mie;
  csr_interrupt_vector_s mip;
  logic [pc_width_lp-1:0] mepc;
  logic cov_en;
  pc_src_e cov_sel;
  logic [pc_width_lp-1:0] pc;
  pc_src_e pc_src;
  logic redirect;
  intr_cause_e interrupt_cause;
  logic [cov_cnt_width_lp-1:0] cov_count;
  logic [cov_cnt_width_lp-1:0] cov_conflict;

  // Reference model state
  logic [15:0] lfsr_q;
  logic [pc_width_lp-1:0] exp_pc;
  pc_src_e exp_src;
  logic exp_redirect;
  intr_cause_e exp_cause;
  logic [cov_cnt_width_lp-1:0] model_cnt [pc_src_count_lp];
  logic [cov_cnt_width_lp-1:0] model_conflict;
  int errors;
  int checks;
  int wraps;

  pc_unit_top
    #(.icache_tag_width_p (tag_width_lp)
     ,.icache_entries_p   (entries_lp)
     ,.boot_pc_p          (boot_pc_lp)
     ,.intr_vector_p      (intr_vector_lp)
    )
    i_dut
    (.clk_i                   (clk)
    ,.rst_i                   (rst)
    ,.hold_down_i             (hold_down)
    ,.decode_i                (decode)
    ,.decode_target_i         (decode_target)
    ,.exe_i                   (exe)
    ,.exe_pc_plus1_i          (exe_pc_plus1)
    ,.exe_pred_or_jump_addr_i (exe_pred_or_jump_addr)
    ,.mem_icache_miss_i       (mem_icache_miss)
    ,.wb_icache_miss_i        (wb_icache_miss)
    ,.wb_pc_i                 (wb_pc)
    ,.alu_jump_now_i          (alu_jump_now)
    ,.alu_jalr_addr_i         (alu_jalr_addr)
    ,.mstatus_i               (mstatus)
    ,.mie_i                   (mie)
    ,.mip_i                   (mip)
    ,.mepc_i                  (mepc)
    ,.cov_en_i                (cov_en)
    ,.cov_sel_i               (cov_sel)
    ,.pc_o                    (pc)
    ,.pc_src_o                (pc_src)
    ,.redirect_o              (redirect)
    ,.interrupt_cause_o       (interrupt_cause)
    ,.cov_count_o             (cov_count)
    ,.cov_conflict_o          (cov_conflict)
    );

  always #(clk_period_lp / 2) clk = ~clk;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = next_lfsr(lfsr_q);
      bits = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  function automatic logic take_bit();
    logic [31:0] b;
    b = take_bits(1);
    return b[0];
  endfunction

  // True about 1 in 8
  function automatic logic rare_bit();
    logic [31:0] b;
    b = take_bits(3);
    return &b[2:0];
  endfunction

  function automatic logic [pc_width_lp-1:0] take_addr();
    logic [31:0] b;
    b = take_bits(pc_width_lp);
    return b[pc_width_lp-1:0];
  endfunction

  task automatic drive_quiet(input logic hold);
    hold_down = hold;
    decode = '0;
    decode_target = '0;
    exe = '0;
    exe_pc_plus1 = '0;
    exe_pred_or_jump_addr = '0;
    mem_icache_miss = 1'b0;
    wb_icache_miss = 1'b0;
    wb_pc = '0;
    alu_jump_now = 1'b0;
    alu_jalr_addr = '0;
    mstatus = '0;
    mie = '0;
    mip = '0;
    mepc = '0;
  endtask

  task automatic drive_random();
    logic [31:0] sel_bits;
    hold_down = rare_bit();
    wb_icache_miss = rare_bit();
    mem_icache_miss = rare_bit();
    exe.icache_miss = rare_bit();
    exe.is_mret_op = rare_bit();
    exe.is_branch_op = take_bit();
    exe.is_jalr_op = take_bit();
    exe.pred_taken = take_bit();
    alu_jump_now = take_bit();
    decode.is_branch_op = take_bit();
    decode.pred_taken = take_bit();
    decode.is_jal_op = rare_bit();
    decode.is_jalr_op = rare_bit();
    mstatus.mie = take_bit();
    mstatus.mpie = take_bit();
    mie.remote = take_bit();
    mie.trace = take_bit();
    mip.remote = take_bit();
    mip.trace = take_bit();
    decode_target = take_addr();
    exe_pc_plus1 = take_addr();
    exe_pred_or_jump_addr = take_addr();
    wb_pc = take_addr();
    mepc = take_addr();
    // Half the jalr targets agree with the prediction
    alu_jalr_addr = take_bit() ? exe_pred_or_jump_addr : take_addr();
    sel_bits = take_bits(4);
    cov_sel = pc_src_e'(sel_bits[3:0]);
  endtask

  // Next PC, source and counts from the inputs now on the pins
  task automatic predict_next();
    logic remote_rdy;
    logic trace_rdy;
    logic intr;
    logic under;
    logic over;
    logic jalr_mis;
    logic take_br;
    logic take_jump;
    logic [7:0] conds;
    int n_true;
    pc_src_e src;
    logic [pc_width_lp-1:0] target;
    remote_rdy = mie.remote & mip.remote;
    trace_rdy = mie.trace & mip.trace;
    intr = mstatus.mie & (remote_rdy | trace_rdy)
           & ~(exe.icache_miss | mem_icache_miss | wb_icache_miss);
    under = exe.is_branch_op & alu_jump_now & ~exe.pred_taken;
    over = exe.is_branch_op & ~alu_jump_now & exe.pred_taken;
    jalr_mis = exe.is_jalr_op & (alu_jalr_addr != exe_pred_or_jump_addr);
    take_br = decode.is_branch_op & decode.pred_taken;
    take_jump = decode.is_jal_op | decode.is_jalr_op;
    if (hold_down) begin
      src = src_reset;
      target = boot_addr_lp;
    end else if (wb_icache_miss) begin
      src = src_icache_miss;
      target = wb_pc;
    end else if (intr) begin
      src = src_interrupt;
      target = intr_addr_lp;
    end else if (exe.is_mret_op) begin
      src = src_mret;
      target = mepc;
    end else if (under || over) begin
      src = src_br_mispredict;
      target = under ? exe_pred_or_jump_addr : exe_pc_plus1;
    end else if (jalr_mis) begin
      src = src_jalr_mispredict;
      target = alu_jalr_addr;
    end else if (take_br || take_jump) begin
      src = take_br ? src_take_br : src_take_jump;
      target = decode_target;
    end else begin
      src = src_seq;
      target = exp_pc + pc_width_lp'(1);
      if (target == '0) begin
        wraps++;
      end
    end
    exp_pc = target;
    exp_src = src;
    exp_redirect = (src >= src_icache_miss) && (src <= src_jalr_mispredict);
    exp_cause = intr_none;
    if (src == src_interrupt) begin
      exp_cause = remote_rdy ? intr_remote : intr_trace;
    end
    conds = {hold_down, wb_icache_miss, intr, exe.is_mret_op,
             under | over, jalr_mis, take_br, take_jump};
    n_true = 0;
    for (int i = 0; i < 8; i++) begin
      if (conds[i]) begin
        n_true++;
      end
    end
    if (cov_en) begin
      if (model_cnt[src] != '1) begin
        model_cnt[src] = model_cnt[src] + cnt_one_lp;
      end
      if ((n_true >= 2) && (model_conflict != '1)) begin
        model_conflict = model_conflict + cnt_one_lp;
      end
    end
  endtask

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic check_outputs();
    logic [cov_cnt_width_lp-1:0] exp_count;
    exp_count = '0;
    if (int'(cov_sel) < pc_src_count_lp) begin
      exp_count = model_cnt[cov_sel];
    end
    checks++;
    if (pc !== exp_pc) begin
      report_mismatch($sformatf("pc_o is %h, expected %h", pc, exp_pc));
    end
    if (pc_src !== exp_src) begin
      report_mismatch($sformatf("pc_src_o is %0d, expected %0d", pc_src, exp_src));
    end
    if (redirect !== exp_redirect) begin
      report_mismatch($sformatf("redirect_o is %b, expected %b", redirect, exp_redirect));
    end
    if (interrupt_cause !== exp_cause) begin
      report_mismatch($sformatf("interrupt_cause_o is %0d, expected %0d",
                                interrupt_cause, exp_cause));
    end
    if (cov_count !== exp_count) begin
      report_mismatch($sformatf("cov_count_o for source %0d is %0d, expected %0d",
                                cov_sel, cov_count, exp_count));
    end
    if (cov_conflict !== model_conflict) begin
      report_mismatch($sformatf("cov_conflict_o is %0d, expected %0d",
                                cov_conflict, model_conflict));
    end
  endtask

  // Results of the last edge are checked at the falling edge before the next drive
  task automatic run_cycle(input int mode, input logic en, input logic [3:0] sel);
    @(negedge clk);
    check_outputs();
    if (mode == mode_random) begin
      drive_random();
    end else begin
      drive_quiet(mode == mode_hold);
      cov_sel = pc_src_e'(sel);
    end
    cov_en = en;
    predict_next();
  endtask

  initial begin
    #((total_cycles_lp + 100) * clk_period_lp);
    $display("Timeout: the run did not finish within %0d clock cycles", total_cycles_lp + 100);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    cov_en = 1'b0;
    cov_sel = src_reset;
    drive_quiet(1'b0);
    lfsr_q = seed_lp;
    errors = 0;
    checks = 0;
    wraps = 0;
    for (int i = 0; i < pc_src_count_lp; i++) begin
      model_cnt[i] = '0;
    end
    model_conflict = '0;
    exp_pc = boot_addr_lp;
    exp_src = src_reset;
    exp_redirect = 1'b0;
    exp_cause = intr_none;
    repeat (2) @(posedge clk);
    @(negedge clk);
    // Reset state with hold-down low
    check_outputs();
    rst = 1'b0;
    drive_quiet(1'b1);
    predict_next();

    // Hold-down keeps the reset state while every counter is read
    for (int s = 0; s < pc_src_count_lp; s++) begin
      run_cycle(mode_hold, 1'b0, s[3:0]);
    end
    // Sequential fetch from near the top of the PC range
    repeat (wrap_cycles_lp) run_cycle(mode_seq, 1'b1, 4'(src_seq));
    repeat (main_cycles_lp) run_cycle(mode_random, 1'b1, 4'd0);
    // Counting off so model counts stay put
    repeat (idle_cycles_lp) run_cycle(mode_random, 1'b0, 4'd0);
    for (int s = 0; s < pc_src_count_lp; s++) begin
      run_cycle(mode_hold, 1'b0, s[3:0]);
    end
    @(negedge clk);
    check_outputs();

    if (wraps == 0) begin
      errors++;
      $display("Sequential fetch never wrapped at the PC width");
    end
    for (int i = 0; i < pc_src_count_lp; i++) begin
      if (model_cnt[i] == '0) begin
        errors++;
        $display("Next-PC source %0d never won during the run", i);
      end
    end
    $display("Summary: %0d checks, %0d errors, %0d conflict cycles",
             checks, errors, model_conflict);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/pc_unit_top.sv
// Next-PC unit top; every input is a level sampled at each rising clk_i and boot_pc_p/intr_vector_p are word indices
`timescale 1ns/10ps
`default_nettype none

module pc_unit_top
  #(parameter int          icache_tag_width_p = 10
   ,parameter int          icache_entries_p   = 64
   ,parameter int unsigned boot_pc_p          = 32'h0000
   ,parameter int unsigned intr_vector_p      = 32'h0010
   ,localparam int icache_addr_width_lp =
      (icache_entries_p > 1) ? $clog2(icache_entries_p) : 1
   ,localparam int pc_width_lp = icache_tag_width_p + icache_addr_width_lp
  )
  (input  logic                                  clk_i
  ,input  logic                                  rst_i
  ,input  logic                                  hold_down_i

  ,input  pc_pkg::decode_s                       decode_i
  ,input  logic [pc_width_lp-1:0]                decode_target_i

  ,input  pc_pkg::exe_s                          exe_i
  ,input  logic [pc_width_lp-1:0]                exe_pc_plus1_i
  ,input  logic [pc_width_lp-1:0]                exe_pred_or_jump_addr_i

  ,input  logic                                  mem_icache_miss_i
  ,input  logic                                  wb_icache_miss_i
  ,input  logic [pc_width_lp-1:0]                wb_pc_i

  ,input  logic                                  alu_jump_now_i
  ,input  logic [pc_width_lp-1:0]                alu_jalr_addr_i

  ,input  csr_pkg::csr_mstatus_s                 mstatus_i
  ,input  csr_pkg::csr_interrupt_vector_s        mie_i
  ,input  csr_pkg::csr_interrupt_vector_s        mip_i
  ,input  logic [pc_width_lp-1:0]                mepc_i

  ,input  logic                                  cov_en_i
  ,input  pc_pkg::pc_src_e                       cov_sel_i

  ,output logic [pc_width_lp-1:0]                pc_o
  ,output pc_pkg::pc_src_e                       pc_src_o
  ,output logic                                  redirect_o
  ,output csr_pkg::intr_cause_e                  interrupt_cause_o
  ,output logic [pc_pkg::cov_cnt_width_lp-1:0]   cov_count_o
  ,output logic [pc_pkg::cov_cnt_width_lp-1:0]   cov_conflict_o
  );

  import pc_pkg::*;
  import csr_pkg::*;

  // Redirect bundle
  logic                   interrupt_ready;
  intr_cause_e            intr_cause;
  logic                   mret;
  logic                   br_mispredict;
  logic [pc_width_lp-1:0] br_recover_addr;
  logic                   jalr_mispredict;
  logic                   take_br;
  logic                   take_jump;

  // Unregistered winner, for the counters
  pc_src_e                pc_src_next;

  pc_redirect_detect
    #(.icache_tag_width_p (icache_tag_width_p)
     ,.icache_entries_p   (icache_entries_p)
    )
    i_detect
    (.decode_i                (decode_i)
    ,.exe_i                   (exe_i)
    ,.exe_pc_plus1_i          (exe_pc_plus1_i)
    ,.exe_pred_or_jump_addr_i (exe_pred_or_jump_addr_i)
    ,.alu_jump_now_i          (alu_jump_now_i)
    ,.alu_jalr_addr_i         (alu_jalr_addr_i)
    ,.mem_icache_miss_i       (mem_icache_miss_i)
    ,.wb_icache_miss_i        (wb_icache_miss_i)
    ,.mstatus_i               (mstatus_i)
    ,.mie_i                   (mie_i)
    ,.mip_i                   (mip_i)
    ,.interrupt_ready_o       (interrupt_ready)
    ,.intr_cause_o            (intr_cause)
    ,.mret_o                  (mret)
    ,.br_mispredict_o         (br_mispredict)
    ,.br_recover_addr_o       (br_recover_addr)
    ,.jalr_mispredict_o       (jalr_mispredict)
    ,.take_br_o               (take_br)
    ,.take_jump_o             (take_jump)
    );

  pc_next_sel
    #(.icache_tag_width_p (icache_tag_width_p)
     ,.icache_entries_p   (icache_entries_p)
     ,.boot_pc_p          (boot_pc_p)
     ,.intr_vector_p      (intr_vector_p)
    )
    i_next_sel
    (.clk_i             (clk_i)
    ,.rst_i             (rst_i)
    ,.hold_down_i       (hold_down_i)
    ,.wb_icache_miss_i  (wb_icache_miss_i)
    ,.wb_pc_i           (wb_pc_i)
    ,.interrupt_ready_i (interrupt_ready)
    ,.intr_cause_i      (intr_cause)
    ,.mret_i            (mret)
    ,.br_mispredict_i   (br_mispredict)
    ,.br_recover_addr_i (br_recover_addr)
    ,.jalr_mispredict_i (jalr_mispredict)
    ,.take_br_i         (take_br)
    ,.take_jump_i       (take_jump)
    ,.mepc_i            (mepc_i)
    ,.alu_jalr_addr_i   (alu_jalr_addr_i)
    ,.decode_target_i   (decode_target_i)
    ,.pc_src_next_o     (pc_src_next)
    ,.pc_o              (pc_o)
    ,.pc_src_o          (pc_src_o)
    ,.redirect_o        (redirect_o)
    ,.interrupt_cause_o (interrupt_cause_o)
    );

  pc_cov_counters i_cov
    (.clk_i             (clk_i)
    ,.rst_i             (rst_i)
    ,.cov_en_i          (cov_en_i)
    ,.pc_src_next_i     (pc_src_next)
    ,.hold_down_i       (hold_down_i)
    ,.wb_icache_miss_i  (wb_icache_miss_i)
    ,.interrupt_ready_i (interrupt_ready)
    ,.mret_i            (mret)
    ,.br_mispredict_i   (br_mispredict)
    ,.jalr_mispredict_i (jalr_mispredict)
    ,.take_br_i         (take_br)
    ,.take_jump_i       (take_jump)
    ,.cov_sel_i         (cov_sel_i)
    ,.cov_count_o       (cov_count_o)
    ,.cov_conflict_o    (cov_conflict_o)
    );

endmodule

`default_nettype wire

// File: verilog/pc_cov_counters.sv
// Counters saturate at all ones and only move while cov_en_i is high; a cov_sel_i past src_seq reads zero
`timescale 1ns/10ps
`default_nettype none

module pc_cov_counters
  (input  logic                                   clk_i
  ,input  logic                                   rst_i
  ,input  logic                                   cov_en_i

  // Winning source this cycle
  ,input  pc_pkg::pc_src_e                        pc_src_next_i

  // Raw conditions, in priority order
  ,input  logic                                   hold_down_i
  ,input  logic                                   wb_icache_miss_i
  ,input  logic                                   interrupt_ready_i
  ,input  logic                                   mret_i
  ,input  logic                                   br_mispredict_i
  ,input  logic                                   jalr_mispredict_i
  ,input  logic                                   take_br_i
  ,input  logic                                   take_jump_i

  // Readout
  ,input  pc_pkg::pc_src_e                        cov_sel_i
  ,output logic [pc_pkg::cov_cnt_width_lp-1:0]    cov_count_o
  ,output logic [pc_pkg::cov_cnt_width_lp-1:0]    cov_conflict_o
  );

  import pc_pkg::*;

  logic [cov_cnt_width_lp-1:0] src_cnt_r [pc_src_count_lp];
  logic [7:0]                  cond_vec;
  logic                        conflict;

  assign cond_vec = {hold_down_i, wb_icache_miss_i, interrupt_ready_i, mret_i,
                     br_mispredict_i, jalr_mispredict_i, take_br_i, take_jump_i};

  // Clearing the lowest set bit leaves something only if two or more were set
  assign conflict = |(cond_vec & (cond_vec - 8'd1));

  // One counter per source, indexed by the enum value
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < pc_src_count_lp; i++) begin
        src_cnt_r[i] <= '0;
      end
    end else if (cov_en_i) begin
      for (int i = 0; i < pc_src_count_lp; i++) begin
        if ((int'(pc_src_next_i) == i) && (src_cnt_r[i] != '1)) begin
          src_cnt_r[i] <= src_cnt_r[i] + 1'b1;
        end
      end
    end
  end

  // Cycles where the priority order decided between competing conditions
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cov_conflict_o <= '0;
    end else if (cov_en_i && conflict && (cov_conflict_o != '1)) begin
      cov_conflict_o <= cov_conflict_o + 1'b1;
    end
  end

  always_comb begin
    if (int'(cov_sel_i) < pc_src_count_lp) begin
      cov_count_o = src_cnt_r[cov_sel_i];
    end else begin
      cov_count_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/pc_next_sel.sv
// Fixed-priority next-PC choice with a one-cycle registered PC; no stall input, a new PC is taken every cycle
`timescale 1ns/10ps
`default_nettype none

module pc_next_sel
  #(parameter int          icache_tag_width_p = 10
   ,parameter int          icache_entries_p   = 64
   ,parameter int unsigned boot_pc_p          = 0
   ,parameter int unsigned intr_vector_p      = 0
   ,localparam int icache_addr_width_lp =
      (icache_entries_p > 1) ? $clog2(icache_entries_p) : 1
   ,localparam int pc_width_lp = icache_tag_width_p + icache_addr_width_lp
  )
  (input  logic                       clk_i
  ,input  logic                       rst_i

  // Highest priority conditions
  ,input  logic                       hold_down_i
  ,input  logic                       wb_icache_miss_i
  ,input  logic [pc_width_lp-1:0]     wb_pc_i

  // Redirect bundle
  ,input  logic                       interrupt_ready_i
  ,input  csr_pkg::intr_cause_e       intr_cause_i
  ,input  logic                       mret_i
  ,input  logic                       br_mispredict_i
  ,input  logic [pc_width_lp-1:0]     br_recover_addr_i
  ,input  logic                       jalr_mispredict_i
  ,input  logic                       take_br_i
  ,input  logic                       take_jump_i

  // Targets
  ,input  logic [pc_width_lp-1:0]     mepc_i
  ,input  logic [pc_width_lp-1:0]     alu_jalr_addr_i
  ,input  logic [pc_width_lp-1:0]     decode_target_i

  ,output pc_pkg::pc_src_e            pc_src_next_o
  ,output logic [pc_width_lp-1:0]     pc_o
  ,output pc_pkg::pc_src_e            pc_src_o
  ,output logic                       redirect_o
  ,output csr_pkg::intr_cause_e       interrupt_cause_o
  );

  import pc_pkg::*;
  import csr_pkg::*;

  localparam logic [pc_width_lp-1:0] boot_pc_lp     = pc_width_lp'(boot_pc_p);
  localparam logic [pc_width_lp-1:0] intr_vector_lp = pc_width_lp'(intr_vector_p);

  logic [pc_width_lp-1:0] pc_plus1;
  logic [pc_width_lp-1:0] pc_next;
  logic                   redirect_next;

  // Wraps at the PC width
  assign pc_plus1 = pc_o + 1'b1;

  // Priority chain, first true condition wins
  always_comb begin
    pc_src_next_o = src_seq;
    pc_next       = pc_plus1;
    if (hold_down_i) begin
      pc_src_next_o = src_reset;
      pc_next       = boot_pc_lp;
    end else if (wb_icache_miss_i) begin
      // Refetch the instruction that missed
      pc_src_next_o = src_icache_miss;
      pc_next       = wb_pc_i;
    end else if (interrupt_ready_i) begin
      pc_src_next_o = src_interrupt;
      pc_next       = intr_vector_lp;
    end else if (mret_i) begin
      pc_src_next_o = src_mret;
      pc_next       = mepc_i;
    end else if (br_mispredict_i) begin
      pc_src_next_o = src_br_mispredict;
      pc_next       = br_recover_addr_i;
    end else if (jalr_mispredict_i) begin
      pc_src_next_o = src_jalr_mispredict;
      pc_next       = alu_jalr_addr_i;
    end else if (take_br_i) begin
      pc_src_next_o = src_take_br;
      pc_next       = decode_target_i;
    end else if (take_jump_i) begin
      pc_src_next_o = src_take_jump;
      pc_next       = decode_target_i;
    end
  end

  // Sources that flush younger work in the pipe
  always_comb begin
    case (pc_src_next_o)
      src_icache_miss,
      src_interrupt,
      src_mret,
      src_br_mispredict,
      src_jalr_mispredict: redirect_next = 1'b1;
      default:             redirect_next = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_o              <= boot_pc_lp;
      pc_src_o          <= src_reset;
      redirect_o        <= 1'b0;
      interrupt_cause_o <= intr_none;
    end else begin
      pc_o              <= pc_next;
      pc_src_o          <= pc_src_next_o;
      redirect_o        <= redirect_next;
      // cause only means something when the interrupt actually won
      interrupt_cause_o <= (pc_src_next_o == src_interrupt) ? intr_cause_i : intr_none;
    end
  end

endmodule

`default_nettype wire

// File: verilog/pc_redirect_detect.sv
// Purely combinational; addresses are word indices of the PC width, exe_pc_plus1_i must already hold exe PC plus one
`timescale 1ns/10ps
`default_nettype none

module pc_redirect_detect
  #(parameter int icache_tag_width_p = 10
   ,parameter int icache_entries_p   = 64
   ,localparam int icache_addr_width_lp =
      (icache_entries_p > 1) ? $clog2(icache_entries_p) : 1
   ,localparam int pc_width_lp = icache_tag_width_p + icache_addr_width_lp
  )
  (// Decode stage
   input  pc_pkg::decode_s                  decode_i

  // Execute stage
  ,input  pc_pkg::exe_s                     exe_i
  ,input  logic [pc_width_lp-1:0]           exe_pc_plus1_i
  ,input  logic [pc_width_lp-1:0]           exe_pred_or_jump_addr_i

  // ALU resolution of the exe instruction
  ,input  logic                             alu_jump_now_i
  ,input  logic [pc_width_lp-1:0]           alu_jalr_addr_i

  // Icache misses further down the pipe
  ,input  logic                             mem_icache_miss_i
  ,input  logic                             wb_icache_miss_i

  // Machine mode CSRs
  ,input  csr_pkg::csr_mstatus_s            mstatus_i
  ,input  csr_pkg::csr_interrupt_vector_s   mie_i
  ,input  csr_pkg::csr_interrupt_vector_s   mip_i

  // Redirect bundle
  ,output logic                             interrupt_ready_o
  ,output csr_pkg::intr_cause_e             intr_cause_o
  ,output logic                             mret_o
  ,output logic                             br_mispredict_o
  ,output logic [pc_width_lp-1:0]           br_recover_addr_o
  ,output logic                             jalr_mispredict_o
  ,output logic                             take_br_o
  ,output logic                             take_jump_o
  );

  import csr_pkg::*;

  logic remote_ready;
  logic trace_ready;
  logic icache_miss_in_flight;
  logic br_under_predict;
  logic br_over_predict;

  // Enabled and pending, per source
  assign remote_ready = mie_i.remote & mip_i.remote;
  assign trace_ready  = mie_i.trace & mip_i.trace;

  // A miss anywhere from exe to wb will refetch, so hold interrupts off
  assign icache_miss_in_flight = exe_i.icache_miss | mem_icache_miss_i | wb_icache_miss_i;

  assign interrupt_ready_o = mstatus_i.mie
                           & (remote_ready | trace_ready)
                           & ~icache_miss_in_flight;

  // Remote has precedence over trace
  always_comb begin
    if (!interrupt_ready_o) begin
      intr_cause_o = intr_none;
    end else if (remote_ready) begin
      intr_cause_o = intr_remote;
    end else begin
      intr_cause_o = intr_trace;
    end
  end

  assign mret_o = exe_i.is_mret_op;

  // Taken but predicted not taken
  assign br_under_predict = exe_i.is_branch_op & alu_jump_now_i & ~exe_i.pred_taken;
  // predicted taken, fell through
  assign br_over_predict  = exe_i.is_branch_op & exe_i.pred_taken & ~alu_jump_now_i;

  assign br_mispredict_o = br_under_predict | br_over_predict;

  // Under-predict goes to the branch target, over-predict back to the fall-through
  assign br_recover_addr_o = br_under_predict ? exe_pred_or_jump_addr_i : exe_pc_plus1_i;

  // Decode guessed a jalr target; the ALU has the real one
  assign jalr_mispredict_o = exe_i.is_jalr_op
                           & (alu_jalr_addr_i != exe_pred_or_jump_addr_i);

  // Early redirects from decode
  assign take_br_o   = decode_i.is_branch_op & decode_i.pred_taken;
  assign take_jump_o = decode_i.is_jal_op | decode_i.is_jalr_op;

endmodule

`default_nettype wire

// File: verilog/csr_pkg.sv
// Machine-mode CSR fields needed by the next-PC unit only; remote and trace are the sole interrupt sources
`default_nettype none

package csr_pkg;

  // mstatus, interrupt enable bits only
  typedef struct packed {
    logic mie;
    logic mpie;
  } csr_mstatus_s;

  // Layout shared by mie and mip
  typedef struct packed {
    logic remote;
    logic trace;
  } csr_interrupt_vector_s;

  // Cause of a taken interrupt
  typedef enum logic [1:0] {
    intr_none   = 2'd0,
    intr_remote = 2'd1,
    intr_trace  = 2'd2
  } intr_cause_e;

endpackage

`default_nettype wire

// File: verilog/pc_pkg.sv
// Next-PC source encoding and pipeline control bits; the source order is also the priority order
`default_nettype none

package pc_pkg;

  // Next-PC sources, highest priority first
  // src_seq must stay last, the counters index by this order
  typedef enum logic [3:0] {
    src_reset           = 4'd0,
    src_icache_miss     = 4'd1,
    src_interrupt       = 4'd2,
    src_mret            = 4'd3,
    src_br_mispredict   = 4'd4,
    src_jalr_mispredict = 4'd5,
    src_take_br         = 4'd6,
    src_take_jump       = 4'd7,
    src_seq             = 4'd8
  } pc_src_e;

  // Number of next-PC sources
  localparam int pc_src_count_lp = 9;

  // Width of every coverage counter
  localparam int cov_cnt_width_lp = 16;

  // Decode stage control
  // pred_taken is the static prediction hint carried in the instruction
  typedef struct packed {
    logic is_branch_op;
    logic is_jal_op;
    logic is_jalr_op;
    logic pred_taken;
  } decode_s;

  // Execute stage control
  typedef struct packed {
    logic is_branch_op;
    logic is_jalr_op;
    logic is_mret_op;
    logic pred_taken;
    // Fetch of this instruction missed in the icache
    logic icache_miss;
  } exe_s;

endpackage

`default_nettype wire
